// File: source/exu_pkg.sv
package exu_pkg;

	typedef logic [63:0] xlen_t;	// data or address word
	typedef logic [4:0] reg_index_t;	// gpr number
	typedef logic [11:0] csr_index_t;	// csr address

	// rd result select
	typedef enum logic [2:0] {
		alu_pass,	// ds1 straight through
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt	// less than sets bit 0
	} alu_op_t;

	// second result select, csr write data or store data
	typedef enum logic [2:0] {
		csr_pass_ds1,
		csr_pass_ds2,	// store data path
		csr_set,	// ds1 | ds2
		csr_clear,	// ds1 & ~ds2
		csr_flip	// ds1 ^ ds2
	} csr_op_t;

	typedef enum logic [2:0] {
		branch_none,
		branch_beq,
		branch_bne,
		branch_blt,
		branch_bge,
		branch_jmp	// jal and jalr
	} branch_t;

	typedef struct packed {
		alu_op_t alu;
		csr_op_t csr;
		branch_t branch;
		logic unsign;	// unsigned compare and zero extend
		logic [3:0] size;	// one-hot, same codes as mem_pkg::access_size_t
		logic load;
		logic store;
	} exu_op_t;

	typedef struct packed {
		logic gpr_write;
		logic csr_write;
		reg_index_t rd_index;
		csr_index_t csr_index;
	} wb_ctrl_t;

endpackage

// File: source/mem_pkg.sv
package mem_pkg;

	typedef logic [3:0] access_size_t;	// one-hot byte count

	localparam access_size_t size_byte = 4'b0001;
	localparam access_size_t size_half = 4'b0010;
	localparam access_size_t size_word = 4'b0100;
	localparam access_size_t size_dword = 4'b1000;

	typedef logic [2:0] byte_offset_t;	// address bits 2:0

	// request toward the bus interface
	typedef struct packed {
		logic read;	// level, high in load state
		logic write;	// level, high in store state
		access_size_t size;
		exu_pkg::xlen_t addr;	// registered target
		exu_pkg::xlen_t wdata;	// registered lane data
	} mem_req_t;

endpackage

// File: source/alu.sv
`timescale 1ns/1ps

module alu (
	input exu_pkg::exu_op_t op,
	input exu_pkg::xlen_t ds1,
	input exu_pkg::xlen_t ds2,
	input exu_pkg::xlen_t as1,
	input exu_pkg::xlen_t as2,
	output exu_pkg::xlen_t alu_rd,
	output exu_pkg::xlen_t alu_aux,
	output exu_pkg::xlen_t target,
	output logic take_branch
);

	logic equal;
	logic less;

	assign equal = (ds1 == ds2);
	assign less = op.unsign ? (ds1 < ds2) : ($signed(ds1) < $signed(ds2));	// shared by slt and blt/bge

	assign target = as1 + as2;	// jump target and load/store address

	// rd result
	always_comb begin
		case (op.alu)
			exu_pkg::alu_pass: alu_rd = ds1;
			exu_pkg::alu_add: alu_rd = ds1 + ds2;
			exu_pkg::alu_sub: alu_rd = ds1 - ds2;
			exu_pkg::alu_and: alu_rd = ds1 & ds2;
			exu_pkg::alu_or: alu_rd = ds1 | ds2;
			exu_pkg::alu_xor: alu_rd = ds1 ^ ds2;
			exu_pkg::alu_slt: alu_rd = exu_pkg::xlen_t'(less);	// 0 or 1
			default: alu_rd = ds1;
		endcase
	end

	// csr write data, also store data via pass_ds2
	always_comb begin
		case (op.csr)
			exu_pkg::csr_pass_ds1: alu_aux = ds1;
			exu_pkg::csr_pass_ds2: alu_aux = ds2;
			exu_pkg::csr_set: alu_aux = ds1 | ds2;	// csrrs
			exu_pkg::csr_clear: alu_aux = ds1 & ~ds2;	// csrrc
			exu_pkg::csr_flip: alu_aux = ds1 ^ ds2;
			default: alu_aux = ds1;
		endcase
	end

	// branch decision
	always_comb begin
		case (op.branch)
			exu_pkg::branch_none: take_branch = 1'b0;
			exu_pkg::branch_beq: take_branch = equal;
			exu_pkg::branch_bne: take_branch = !equal;
			exu_pkg::branch_blt: take_branch = less;	// bltu when unsign
			exu_pkg::branch_bge: take_branch = !less;	// bgeu when unsign
			exu_pkg::branch_jmp: take_branch = 1'b1;	// always taken
			default: take_branch = 1'b0;
		endcase
	end

endmodule

// File: source/lsu_sequencer.sv
`timescale 1ns/1ps

module lsu_sequencer (
	input logic clk,
	input logic rst,
	input logic issue_valid,
	input exu_pkg::exu_op_t op,
	input mem_pkg::byte_offset_t offset,
	input logic down_hold,
	input logic mem_ready,
	output logic mem_read,
	output logic mem_write,
	output logic busy,
	output logic load_capture,
	output logic load_mis,
	output logic store_mis
);

	typedef enum logic [1:0] {
		idle,
		load,	// read strobe up, wait for ready
		load_data,	// bus data valid this cycle
		store	// write strobe up, wait for ready
	} state_t;

	state_t state;
	logic misaligned;
	logic start_load;
	logic start_store;

	// access must stay inside one dword
	always_comb begin
		case (op.size)
			mem_pkg::size_half: misaligned = (offset == 3'd7);
			mem_pkg::size_word: misaligned = (offset[1:0] != 2'b00);
			mem_pkg::size_dword: misaligned = (offset != 3'd0);
			default: misaligned = 1'b0;	// byte fits anywhere
		endcase
	end

	assign load_mis = issue_valid & op.load & misaligned;
	assign store_mis = issue_valid & op.store & misaligned;

	assign start_load = (state == idle) & issue_valid & op.load & !misaligned;
	assign start_store = (state == idle) & issue_valid & op.store & !misaligned;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
		end else if (!down_hold) begin	// later stage stalled, freeze
			case (state)
				idle: begin
					if (start_load) begin
						state <= load;
					end else if (start_store) begin
						state <= store;
					end
				end
				load: if (mem_ready) state <= load_data;	// data follows one cycle later
				load_data: state <= idle;
				store: if (mem_ready) state <= idle;
				default: state <= idle;
			endcase
		end
	end

	assign mem_read = (state == load);
	assign mem_write = (state == store);
	assign load_capture = (state == load_data);

	// stall issue until the result can register
	assign busy = start_load | start_store | (state == load) | ((state == store) & !mem_ready);

endmodule

// File: source/byte_shifter.sv
`timescale 1ns/1ps

module byte_shifter (
	input exu_pkg::exu_op_t op,
	input mem_pkg::byte_offset_t offset,
	input exu_pkg::xlen_t wdata,
	input exu_pkg::xlen_t rdata,
	output exu_pkg::xlen_t wdata_lane,
	output exu_pkg::xlen_t load_data
);

	logic [5:0] shamt;	// offset in bits
	exu_pkg::xlen_t rshift;

	assign shamt = {offset, 3'b000};

	assign wdata_lane = wdata << shamt;	// low bytes onto addressed lanes
	assign rshift = rdata >> shamt;	// addressed lanes down to bit 0

	// mask to access size then extend
	always_comb begin
		case (op.size)
			mem_pkg::size_byte: begin
				load_data = op.unsign ? {56'b0, rshift[7:0]}
					: {{56{rshift[7]}}, rshift[7:0]};	// lb / lbu
			end
			mem_pkg::size_half: begin
				load_data = op.unsign ? {48'b0, rshift[15:0]}
					: {{48{rshift[15]}}, rshift[15:0]};	// lh / lhu
			end
			mem_pkg::size_word: begin
				load_data = op.unsign ? {32'b0, rshift[31:0]}
					: {{32{rshift[31]}}, rshift[31:0]};	// lw / lwu
			end
			default: load_data = rshift;	// ld, full word
		endcase
	end

endmodule

// File: source/exu_pipe_reg.sv
`timescale 1ns/1ps

module exu_pipe_reg (
	input logic clk,
	input logic rst,
	input logic issue_valid,
	input exu_pkg::wb_ctrl_t wb,
	input exu_pkg::xlen_t pc,
	input exu_pkg::xlen_t tval_in,
	input exu_pkg::reg_index_t rs1_index,
	input exu_pkg::reg_index_t rs2_index,
	input logic war_check,
	input logic issue_system,
	input logic issue_jmp,
	input logic down_hold,
	input logic down_nop,
	input logic down_war,
	input exu_pkg::xlen_t alu_rd,
	input exu_pkg::xlen_t alu_aux,
	input exu_pkg::xlen_t target,
	input exu_pkg::xlen_t wdata_lane,
	input exu_pkg::xlen_t load_data,
	input logic take_branch,
	input logic busy,
	input logic load_capture,
	input logic load_mis,
	input logic store_mis,
	input logic mem_read,
	input logic mem_write,
	input mem_pkg::access_size_t size,
	output logic hold,
	output logic nop,
	output logic war,
	output exu_pkg::xlen_t rd_data,
	output exu_pkg::xlen_t csr_data,
	output exu_pkg::xlen_t new_pc,
	output exu_pkg::xlen_t pc_out,
	output exu_pkg::xlen_t tval,
	output exu_pkg::wb_ctrl_t wb_out,
	output logic pc_jmp,
	output logic valid,
	output logic system,
	output logic load_addr_mis,
	output logic store_addr_mis,
	output mem_pkg::mem_req_t mem_req
);

	logic exception;
	logic retire;	// op completes this cycle without trap
	exu_pkg::xlen_t addr_q;
	exu_pkg::xlen_t wdata_q;

	assign exception = load_mis | store_mis;
	assign retire = issue_valid & !busy & !exception;

	// flow control back to issue
	assign hold = busy | down_hold;
	assign nop = exception | issue_system | issue_jmp | down_nop;	// flush younger ops
	assign war = (war_check & wb.gpr_write
		& ((rs1_index == wb.rd_index) | (rs2_index == wb.rd_index))) | down_war;

	always_ff @(posedge clk) begin
		if (!down_hold) begin
			rd_data <= load_capture ? load_data : alu_rd;
			csr_data <= alu_aux;
			new_pc <= target;
			pc_out <= pc;
			tval <= exception ? target : tval_in;	// faulting address on trap
			addr_q <= target;	// bus addr one cycle behind
			wdata_q <= wdata_lane;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || down_nop) begin
			valid <= 1'b0;
			pc_jmp <= 1'b0;
			system <= 1'b0;
			load_addr_mis <= 1'b0;
			store_addr_mis <= 1'b0;
			wb_out.gpr_write <= 1'b0;
			wb_out.csr_write <= 1'b0;
		end else if (!down_hold) begin
			valid <= (issue_valid & !busy) | exception;	// traps pass on as valid
			pc_jmp <= retire & take_branch;
			system <= (issue_valid & issue_system) | exception;
			load_addr_mis <= load_mis;
			store_addr_mis <= store_mis;
			wb_out.gpr_write <= retire & wb.gpr_write;	// no write from a trapped op
			wb_out.csr_write <= retire & wb.csr_write;
			wb_out.rd_index <= wb.rd_index;
			wb_out.csr_index <= wb.csr_index;
		end
	end

	assign mem_req = '{read: mem_read, write: mem_write, size: size, addr: addr_q, wdata: wdata_q};

endmodule

// File: source/exu.sv
`timescale 1ns/1ps

module exu (
	input logic clk,
	input logic rst,
	input logic issue_valid,
	input exu_pkg::exu_op_t op,
	input exu_pkg::wb_ctrl_t wb,
	input exu_pkg::xlen_t ds1,
	input exu_pkg::xlen_t ds2,
	input exu_pkg::xlen_t as1,
	input exu_pkg::xlen_t as2,
	input exu_pkg::xlen_t pc,
	input exu_pkg::xlen_t tval_in,
	input exu_pkg::reg_index_t rs1_index,
	input exu_pkg::reg_index_t rs2_index,
	input logic war_check,
	input logic issue_system,
	input logic issue_jmp,
	input logic down_hold,
	input logic down_nop,
	input logic down_war,
	input logic mem_ready,	// one-cycle pulse
	input exu_pkg::xlen_t mem_rdata,	// valid the cycle after mem_ready
	output mem_pkg::mem_req_t mem_req,
	output logic hold,
	output logic nop,
	output logic war,
	output exu_pkg::xlen_t rd_data,
	output exu_pkg::xlen_t csr_data,
	output exu_pkg::xlen_t new_pc,
	output exu_pkg::xlen_t pc_out,
	output exu_pkg::xlen_t tval,
	output exu_pkg::wb_ctrl_t wb_out,
	output logic pc_jmp,
	output logic valid,
	output logic system,
	output logic load_addr_mis,
	output logic store_addr_mis
);

	exu_pkg::xlen_t alu_rd;
	exu_pkg::xlen_t alu_aux;	// csr data or store data
	exu_pkg::xlen_t target;
	exu_pkg::xlen_t wdata_lane;
	exu_pkg::xlen_t load_data;
	mem_pkg::byte_offset_t offset;
	logic take_branch;
	logic mem_read;
	logic mem_write;
	logic busy;
	logic load_capture;
	logic load_mis;
	logic store_mis;

	assign offset = target[2:0];	// byte lane of the access

	alu u_alu (
		.op(op), .ds1(ds1), .ds2(ds2), .as1(as1), .as2(as2),
		.alu_rd(alu_rd), .alu_aux(alu_aux), .target(target), .take_branch(take_branch)
	);

	lsu_sequencer u_lsu_sequencer (
		.clk(clk), .rst(rst), .issue_valid(issue_valid), .op(op), .offset(offset),
		.down_hold(down_hold), .mem_ready(mem_ready),
		.mem_read(mem_read), .mem_write(mem_write), .busy(busy),
		.load_capture(load_capture), .load_mis(load_mis), .store_mis(store_mis)
	);

	byte_shifter u_byte_shifter (
		.op(op), .offset(offset), .wdata(alu_aux), .rdata(mem_rdata),
		.wdata_lane(wdata_lane), .load_data(load_data)
	);

	exu_pipe_reg u_exu_pipe_reg (
		.clk(clk), .rst(rst), .issue_valid(issue_valid), .wb(wb), .pc(pc),
		.tval_in(tval_in), .rs1_index(rs1_index), .rs2_index(rs2_index),
		.war_check(war_check), .issue_system(issue_system), .issue_jmp(issue_jmp),
		.down_hold(down_hold), .down_nop(down_nop), .down_war(down_war),
		.alu_rd(alu_rd), .alu_aux(alu_aux), .target(target), .wdata_lane(wdata_lane),
		.load_data(load_data), .take_branch(take_branch), .busy(busy),
		.load_capture(load_capture), .load_mis(load_mis), .store_mis(store_mis),
		.mem_read(mem_read), .mem_write(mem_write), .size(op.size),
		.hold(hold), .nop(nop), .war(war), .rd_data(rd_data), .csr_data(csr_data),
		.new_pc(new_pc), .pc_out(pc_out), .tval(tval), .wb_out(wb_out), .pc_jmp(pc_jmp),
		.valid(valid), .system(system), .load_addr_mis(load_addr_mis),
		.store_addr_mis(store_addr_mis), .mem_req(mem_req)
	);

endmodule

// File: verification/exu_vectors.svh
`ifndef EXU_VECTORS_SVH
`define EXU_VECTORS_SVH

// columns: op, ds1, ds2, as1, as2, mem, exp_rd, exp_aux, exp_jmp, exp_mis
// mem is the word returned on a load, or the expected bus wdata on a store
// op_of args: alu, csr, branch, unsign, size bytes, load, store
// alu 0 pass 1 add 2 sub 3 and 4 or 5 xor 6 slt; csr 0 ds1 1 ds2 2 set 3 clear 4 flip
// branch 0 none 1 beq 2 bne 3 blt 4 bge 5 jmp; exp_mis is {load, store}
typedef struct {
	exu_pkg::exu_op_t op;
	exu_pkg::xlen_t ds1;
	exu_pkg::xlen_t ds2;
	exu_pkg::xlen_t as1;
	exu_pkg::xlen_t as2;
	exu_pkg::xlen_t mem;
	exu_pkg::xlen_t exp_rd;
	exu_pkg::xlen_t exp_aux;
	logic exp_jmp;
	logic [1:0] exp_mis;
} vec_t;

localparam int num_rows = 37;
localparam logic [63:0] neg1 = 64'hFFFF_FFFF_FFFF_FFFF;
localparam logic [63:0] memw = 64'hF1E2_D3C4_B5A6_9788;	// lanes 0..7 = 88 97 a6 b5 c4 d3 e2 f1
localparam logic [63:0] sdat = 64'h1122_3344_5566_7788;

vec_t vectors [num_rows];

function automatic exu_pkg::exu_op_t op_of(int alu, int csr, int br, bit uns, int size,
		bit ld, bit st);
	exu_pkg::exu_op_t o;
	o.alu = exu_pkg::alu_op_t'(alu);
	o.csr = exu_pkg::csr_op_t'(csr);
	o.branch = exu_pkg::branch_t'(br);
	o.unsign = uns;
	o.size = size[3:0];	// already one-hot
	o.load = ld;
	o.store = st;
	return o;
endfunction

task automatic fill_table();
	vectors = '{
		'{op_of(0, 0, 0, 0, 8, 0, 0), 'hC, 'hA, 0, 0, 0, 'hC, 'hC, 0, 0},
		'{op_of(1, 1, 0, 0, 8, 0, 0), 'hC, 'hA, 0, 0, 0, 'h16, 'hA, 0, 0},
		'{op_of(2, 2, 0, 0, 8, 0, 0), 'hC, 'hA, 0, 0, 0, 'h2, 'hE, 0, 0},
		'{op_of(3, 3, 0, 0, 8, 0, 0), 'hC, 'hA, 0, 0, 0, 'h8, 'h4, 0, 0},
		'{op_of(4, 4, 0, 0, 8, 0, 0), 'hC, 'hA, 0, 0, 0, 'hE, 'h6, 0, 0},
		'{op_of(5, 0, 0, 0, 8, 0, 0), 'hC, 'hA, 0, 0, 0, 'h6, 'hC, 0, 0},
		'{op_of(6, 1, 0, 0, 8, 0, 0), neg1, 1, 0, 0, 0, 1, 1, 0, 0},	// signed slt
		'{op_of(6, 1, 0, 1, 8, 0, 0), neg1, 1, 0, 0, 0, 0, 1, 0, 0},	// sltu
		'{op_of(0, 0, 1, 0, 8, 0, 0), 5, 5, 'h1000, 'h20, 0, 5, 5, 1, 0},
		'{op_of(0, 0, 1, 0, 8, 0, 0), 5, 7, 'h1000, 'h20, 0, 5, 5, 0, 0},
		'{op_of(0, 0, 2, 0, 8, 0, 0), 5, 7, 'h1000, 'h20, 0, 5, 5, 1, 0},
		'{op_of(0, 0, 2, 0, 8, 0, 0), 5, 5, 'h1000, 'h20, 0, 5, 5, 0, 0},	// bne equal
		'{op_of(0, 0, 3, 0, 8, 0, 0), neg1, 1, 'h1000, 'h20, 0, neg1, neg1, 1, 0},
		'{op_of(0, 0, 3, 1, 8, 0, 0), neg1, 1, 'h1000, 'h20, 0, neg1, neg1, 0, 0},
		'{op_of(0, 0, 3, 0, 8, 0, 0), 5, 5, 'h1000, 'h20, 0, 5, 5, 0, 0},	// blt equal
		'{op_of(0, 0, 4, 0, 8, 0, 0), 7, 5, 'h1000, 'h20, 0, 7, 7, 1, 0},
		'{op_of(0, 0, 4, 0, 8, 0, 0), 5, 7, 'h1000, 'h20, 0, 5, 5, 0, 0},
		'{op_of(0, 0, 4, 0, 8, 0, 0), 5, 5, 'h1000, 'h20, 0, 5, 5, 1, 0},	// bge equal
		'{op_of(0, 0, 5, 0, 8, 0, 0), 5, 7, 'h1000, 'h20, 0, 5, 5, 1, 0},
		'{op_of(0, 0, 0, 0, 8, 0, 0), 5, 5, 'h1000, 'h20, 0, 5, 5, 0, 0},
		'{op_of(0, 0, 0, 0, 1, 1, 0), 0, 0, 'h2000, 1, memw, 64'hFFFFFFFFFFFFFF97, 0, 0, 0},
		'{op_of(0, 0, 0, 1, 1, 1, 0), 0, 0, 'h2000, 1, memw, 'h97, 0, 0, 0},
		'{op_of(0, 0, 0, 0, 2, 1, 0), 0, 0, 'h2000, 2, memw, 64'hFFFFFFFFFFFFB5A6, 0, 0, 0},
		'{op_of(0, 0, 0, 1, 2, 1, 0), 0, 0, 'h2000, 6, memw, 'hF1E2, 0, 0, 0},
		'{op_of(0, 0, 0, 0, 4, 1, 0), 0, 0, 'h2000, 4, memw, 64'hFFFFFFFFF1E2D3C4, 0, 0, 0},
		'{op_of(0, 0, 0, 1, 4, 1, 0), 0, 0, 'h2000, 0, memw, 'hB5A69788, 0, 0, 0},
		'{op_of(0, 0, 0, 0, 8, 1, 0), 0, 0, 'h2000, 0, memw, memw, 0, 0, 0},
		'{op_of(0, 1, 0, 0, 1, 0, 1), 0, sdat, 'h3000, 3, 64'h4455667788000000, 0, 0, 0, 0},
		'{op_of(0, 1, 0, 0, 2, 0, 1), 0, sdat, 'h3000, 6, 64'h7788000000000000, 0, 0, 0, 0},
		'{op_of(0, 1, 0, 0, 4, 0, 1), 0, sdat, 'h3000, 4, 64'h5566778800000000, 0, 0, 0, 0},
		'{op_of(0, 1, 0, 0, 8, 0, 1), 0, sdat, 'h3000, 0, sdat, 0, 0, 0, 0},
		'{op_of(0, 0, 0, 0, 2, 1, 0), 0, 0, 'h2000, 7, 0, 0, 0, 0, 2'b10},
		'{op_of(0, 0, 0, 0, 4, 1, 0), 0, 0, 'h2000, 2, 0, 0, 0, 0, 2'b10},
		'{op_of(0, 0, 0, 0, 8, 1, 0), 0, 0, 'h2000, 4, 0, 0, 0, 0, 2'b10},
		'{op_of(0, 1, 0, 0, 2, 0, 1), 0, sdat, 'h3000, 7, 0, 0, 0, 0, 2'b01},
		'{op_of(0, 1, 0, 0, 4, 0, 1), 0, sdat, 'h3000, 1, 0, 0, 0, 0, 2'b01},
		'{op_of(0, 1, 0, 0, 8, 0, 1), 0, sdat, 'h3000, 3, 0, 0, 0, 0, 2'b01}
	};
endtask

`endif

// File: verification/exu_tb.sv
`timescale 1ns/1ps

module exu_tb;

	`include "exu_vectors.svh"

	localparam int max_cycles = num_rows * 10 + 20;
	localparam int row_cap = 10;

	logic clk;
	logic rst;
	logic issue_valid;
	exu_pkg::exu_op_t op;
	exu_pkg::wb_ctrl_t wb;
	exu_pkg::xlen_t ds1;
	exu_pkg::xlen_t ds2;
	exu_pkg::xlen_t as1;
	exu_pkg::xlen_t as2;
	exu_pkg::xlen_t pc;
	exu_pkg::xlen_t tval_in;
	exu_pkg::reg_index_t rs1_index;
	exu_pkg::reg_index_t rs2_index;
	logic war_check;
	logic issue_system;
	logic issue_jmp;
	logic down_hold;
	logic down_nop;
	logic down_war;
	logic mem_ready;
	exu_pkg::xlen_t mem_rdata;
	mem_pkg::mem_req_t mem_req;
	logic hold;
	logic nop;
	logic war;
	exu_pkg::xlen_t rd_data;
	exu_pkg::xlen_t csr_data;
	exu_pkg::xlen_t new_pc;
	exu_pkg::xlen_t pc_out;
	exu_pkg::xlen_t tval;
	exu_pkg::wb_ctrl_t wb_out;
	logic pc_jmp;
	logic valid;
	logic system;
	logic load_addr_mis;
	logic store_addr_mis;

	int errors = 0;
	int timeouts = 0;
	int cycles = 0;
	integer seed = 55;
	logic seen_read;
	logic seen_write;
	exu_pkg::xlen_t cur_word;	// word the responder returns
	exu_pkg::xlen_t bus_wdata;	// captured while the write strobe is up
	exu_pkg::xlen_t bus_addr;
	mem_pkg::access_size_t bus_size;

	exu DUT (.*);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("Run stopped: the cycle limit was reached before the tests ended.");
			$display("Something failed");
			$finish;
		end
	end

	// bus model, ready 1 to 3 cycles after a strobe, data one cycle after ready
	initial begin
		int delay;
		mem_ready = 1'b0;
		mem_rdata = '0;
		forever begin
			@(posedge clk);
			#2;
			if (mem_req.read || mem_req.write) begin
				seen_read = seen_read | mem_req.read;
				seen_write = seen_write | mem_req.write;
				delay = 1 + ($unsigned($random(seed)) % 3);
				repeat (delay) @(posedge clk);
				#1;
				mem_ready = 1'b1;
				bus_wdata = mem_req.wdata;	// held stable under the strobe
				bus_addr = mem_req.addr;
				bus_size = mem_req.size;
				@(posedge clk);
				#1;
				mem_ready = 1'b0;
				mem_rdata = cur_word;
			end
		end
	end

	task automatic check_value(string what, logic [63:0] got, logic [63:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic run_row(int i);
		vec_t r;
		logic issue_hold;
		logic issue_nop;
		logic read_seen;
		logic write_seen;
		int hold_low;
		int n;
		logic [63:0] addr;
		exu_pkg::xlen_t row_pc;
		r = vectors[i];
		addr = r.as1 + r.as2;
		row_pc = 64'h8000_0000 + 64'(i * 4);
		hold_low = 0;
		n = 0;
		@(posedge clk);
		#1;
		op = r.op;
		ds1 = r.ds1;
		ds2 = r.ds2;
		as1 = r.as1;
		as2 = r.as2;
		pc = row_pc;
		cur_word = r.mem;
		seen_read = 1'b0;
		seen_write = 1'b0;
		issue_valid = 1'b1;
		#1;
		issue_hold = hold;
		issue_nop = nop;
		forever begin
			@(posedge clk);
			#1;
			if (valid) break;
			#1;
			if (!hold) hold_low++;
			n++;
			if (n >= row_cap) break;
		end
		issue_valid = 1'b0;
		if (!valid) begin
			$display("Row %0d timed out because valid never came up.", i);
			timeouts++;
			return;
		end
		read_seen = seen_read | mem_req.read;	// strobe raised at the last edge too
		write_seen = seen_write | mem_req.write;
		check_value($sformatf("row %0d new_pc", i), new_pc, addr);
		check_value($sformatf("row %0d pc_out", i), pc_out, row_pc);
		check_value($sformatf("row %0d mis flags", i), {load_addr_mis, store_addr_mis}, r.exp_mis);
		check_value($sformatf("row %0d system", i), system, |r.exp_mis);
		if (r.exp_mis != 2'b00) begin
			check_value($sformatf("row %0d strobes", i), {read_seen, write_seen}, 0);
			check_value($sformatf("row %0d issue nop", i), issue_nop, 1);
			check_value($sformatf("row %0d tval", i), tval, addr);
			return;
		end
		check_value($sformatf("row %0d pc_jmp", i), pc_jmp, r.exp_jmp);
		check_value($sformatf("row %0d read seen", i), read_seen, r.op.load);
		check_value($sformatf("row %0d write seen", i), write_seen, r.op.store);
		check_value($sformatf("row %0d wb_out", i), wb_out, wb);
		if (r.op.load || r.op.store) begin
			check_value($sformatf("row %0d bus addr", i), bus_addr, addr);
			check_value($sformatf("row %0d bus size", i), bus_size, r.op.size);
		end
		if (r.op.load) begin
			check_value($sformatf("row %0d load rd", i), rd_data, r.exp_rd);
			check_value($sformatf("row %0d issue hold", i), issue_hold, 1);
			check_value($sformatf("row %0d hold gaps", i), hold_low, 1);	// only load_data
		end else if (r.op.store) begin
			check_value($sformatf("row %0d bus wdata", i), bus_wdata, r.mem);
		end else begin
			check_value($sformatf("row %0d rd", i), rd_data, r.exp_rd);
			check_value($sformatf("row %0d csr", i), csr_data, r.exp_aux);
		end
	endtask

	task automatic war_case(logic chk, logic wr, int rd, int rs1, int rs2, logic exp);
		#1;
		war_check = chk;
		wb.gpr_write = wr;
		wb.rd_index = rd[4:0];
		rs1_index = rs1[4:0];
		rs2_index = rs2[4:0];
		#1;
		check_value($sformatf("war for rd %0d rs %0d/%0d", rd, rs1, rs2), war, exp);
	endtask

	task automatic flow_checks();
		war_case(1, 1, 5, 5, 9, 1);
		war_case(1, 1, 5, 3, 5, 1);
		war_case(1, 1, 5, 3, 4, 0);
		war_case(0, 1, 5, 5, 5, 0);
		war_case(1, 0, 5, 5, 5, 0);
		war_check = 1'b0;
		wb.gpr_write = 1'b1;	// write pending when down_nop hits
		@(posedge clk);
		#1;
		op = op_of(1, 0, 0, 0, 8, 0, 0);
		ds1 = 1;
		ds2 = 2;
		issue_valid = 1'b1;
		@(posedge clk);
		#1;
		ds1 = 4;
		ds2 = 4;
		down_hold = 1'b1;	// stall with a new op waiting
		repeat (2) @(posedge clk);
		#1;
		check_value("rd under down_hold", rd_data, 3);
		check_value("valid under down_hold", valid, 1);
		check_value("hold under down_hold", hold, 1);
		down_hold = 1'b0;
		@(posedge clk);
		#1;
		check_value("rd after down_hold", rd_data, 8);
		down_nop = 1'b1;
		@(posedge clk);
		#1;
		check_value("valid after down_nop", valid, 0);
		check_value("gpr write after down_nop", wb_out.gpr_write, 0);
		check_value("csr write after down_nop", wb_out.csr_write, 0);
		down_nop = 1'b0;
		issue_valid = 1'b0;
	endtask

	initial begin
		rst = 1'b1;
		issue_valid = 1'b1;	// misaligned load pending while reset is up
		op = op_of(0, 0, 0, 0, 8, 1, 0);
		wb = '{gpr_write: 1'b1, csr_write: 1'b1, rd_index: 5'd5, csr_index: 12'h300};
		ds1 = '0;
		ds2 = '0;
		as1 = '0;
		as2 = 64'd4;
		pc = 64'h8000_0000;
		tval_in = '0;
		rs1_index = 5'd1;
		rs2_index = 5'd2;
		war_check = 1'b0;
		issue_system = 1'b0;
		issue_jmp = 1'b0;
		down_hold = 1'b0;
		down_nop = 1'b0;
		down_war = 1'b0;
		cur_word = '0;
		fill_table();
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		issue_valid = 1'b0;
		op = '0;
		as2 = '0;
		check_value("flags after reset", {valid, system, load_addr_mis, store_addr_mis}, 0);
		check_value("strobes after reset", {mem_req.read, mem_req.write}, 0);
		for (int i = 0; i < num_rows; i++) begin
			run_row(i);
		end
		flow_checks();
		$display("errors: %0d wrong values, %0d row timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: src.f
+incdir+verification
source/exu_pkg.sv
source/mem_pkg.sv
source/alu.sv
source/lsu_sequencer.sv
source/byte_shifter.sv
source/exu_pipe_reg.sv
source/exu.sv
verification/exu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= exu_tb
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
PASS_MSG ?= Everything OK
VFLAGS ?= --timing

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
